// ==== verilog/ddcPkg.sv ====
package ddcPkg;

    // sample and oscillator widths
    localparam int sampleWidth = 16;
    localparam int loWidth = 16;    // full scale is 32767

    // phase accumulator and table addressing
    localparam int phaseWidth = 32;
    localparam int lutAddrWidth = 6;

    // CIC decimator
    localparam int cicRate = 4;
    localparam int cicOrder = 2;
    localparam int cicShift = 4;    // rate to the power of order is 16

    // halfband decimator
    localparam int hbRate = 2;

    // host register map
    localparam int regAddrWidth = 12;
    localparam logic [regAddrWidth-1:0] ddcCenterFreqAddr = 12'h000;
    localparam logic [regAddrWidth-1:0] ddcControlAddr = 12'h004;

    // control register bits
    localparam int bypassCicBit = 0;
    localparam int bypassHbBit = 1;
    localparam int swapIqBit = 2;

endpackage

// ==== verilog/ddcRegs.sv ====
module ddcRegs import ddcPkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [regAddrWidth-1:0] addr,
    input  logic [31:0]             dataIn,
    input  logic [3:0]              byteEn,
    input  logic                    cs,
    input  logic                    wr,
    output logic [31:0]             dataOut,
    output logic [phaseWidth-1:0]   centerFreq,
    output logic                    bypassCic,
    output logic                    bypassHb,
    output logic                    swapIq
);

    logic writeEn;

    assign writeEn = cs && wr;

    always_ff @(posedge clk) begin
        if (rst) begin
            centerFreq <= '0;
            bypassCic <= 1'b0;
            bypassHb <= 1'b0;
            swapIq <= 1'b0;
        end else if (writeEn) begin
            case (addr)
                ddcCenterFreqAddr: begin
                    for (int b = 0; b < 4; b++) begin
                        if (byteEn[b]) begin
                            centerFreq[8*b +: 8] <= dataIn[8*b +: 8];
                        end
                    end
                end
                ddcControlAddr: begin
                    if (byteEn[0]) begin    // flags all live in lane 0
                        bypassCic <= dataIn[bypassCicBit];
                        bypassHb <= dataIn[bypassHbBit];
                        swapIq <= dataIn[swapIqBit];
                    end
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        dataOut = '0;    // unmapped or deselected reads return zero
        if (cs) begin
            case (addr)
                ddcCenterFreqAddr: dataOut = centerFreq;
                ddcControlAddr: begin
                    dataOut[bypassCicBit] = bypassCic;
                    dataOut[bypassHbBit] = bypassHb;
                    dataOut[swapIqBit] = swapIq;
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== verilog/ddcNco.sv ====
module ddcNco import ddcPkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      sampleValid,
    input  logic [phaseWidth-1:0]     centerFreq,
    output logic signed [loWidth-1:0] loCos,
    output logic signed [loWidth-1:0] loSin
);

    logic [phaseWidth-1:0] phase;
    logic [lutAddrWidth-1:0] lutAddr;
    logic signed [loWidth-1:0] cosTable [2**lutAddrWidth];
    logic signed [loWidth-1:0] sinTable [2**lutAddrWidth];

    // full-scale table entry rounded to the nearest integer
    function automatic logic signed [loWidth-1:0] lutEntry(input int idx, input bit sine);
        real angle;
        real fullScale;
        real value;
        angle = 6.283185307179586 * real'(idx) / real'(2**lutAddrWidth);
        fullScale = real'((2**(loWidth-1)) - 1);
        if (sine) begin
            value = fullScale * $sin(angle);
        end else begin
            value = fullScale * $cos(angle);
        end
        return loWidth'(int'(value));
    endfunction

    for (genvar k = 0; k < 2**lutAddrWidth; k++) begin : gLut
        assign cosTable[k] = lutEntry(k, 1'b0);
        assign sinTable[k] = lutEntry(k, 1'b1);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= '0;
        end else if (sampleValid) begin
            phase <= phase + centerFreq;    // current sample uses the old phase
        end
    end

    assign lutAddr = phase[phaseWidth-1 -: lutAddrWidth];
    assign loCos = cosTable[lutAddr];
    assign loSin = sinTable[lutAddr];

endmodule

// ==== verilog/ddcMixer.sv ====
module ddcMixer import ddcPkg::*; (
    input  logic                          clk,
    input  logic                          rst,
    input  logic signed [sampleWidth-1:0] sampleIn,
    input  logic                          sampleValid,
    input  logic signed [loWidth-1:0]     loCos,
    input  logic signed [loWidth-1:0]     loSin,
    input  logic                          swapIq,
    output logic signed [sampleWidth-1:0] iMix,
    output logic signed [sampleWidth-1:0] qMix,
    output logic                          mixValid
);

    logic signed [sampleWidth+loWidth:0] iProd;
    logic signed [sampleWidth+loWidth:0] qProd;
    logic signed [sampleWidth-1:0] iScaled;
    logic signed [sampleWidth-1:0] qScaled;

    function automatic logic signed [sampleWidth-1:0] scaleSat(
        input logic signed [sampleWidth+loWidth:0] product
    );
        logic signed [sampleWidth+loWidth:0] shifted;
        shifted = product >>> (loWidth - 1);    // drop the oscillator's fractional bits
        if (shifted > (2**(sampleWidth-1)) - 1) begin
            return {1'b0, {(sampleWidth-1){1'b1}}};
        end else if (shifted < -(2**(sampleWidth-1))) begin
            return {1'b1, {(sampleWidth-1){1'b0}}};
        end
        return shifted[sampleWidth-1:0];
    endfunction

    assign iProd = sampleIn * loCos;
    assign qProd = -(sampleIn * loSin);
    assign iScaled = scaleSat(iProd);
    assign qScaled = scaleSat(qProd);

    always_ff @(posedge clk) begin
        if (rst) begin
            mixValid <= 1'b0;
        end else begin
            mixValid <= sampleValid;
        end
    end

    always_ff @(posedge clk) begin
        if (sampleValid) begin
            iMix <= swapIq ? qScaled : iScaled;
            qMix <= swapIq ? iScaled : qScaled;
        end
    end

endmodule

// ==== verilog/cicDecimator.sv ====
module cicDecimator import ddcPkg::*; (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          bypass,
    input  logic signed [sampleWidth-1:0] sampleIn,
    input  logic                          sampleValid,
    output logic signed [sampleWidth-1:0] sampleOut,
    output logic                          outValid
);

    // register growth is order times log2 of the rate
    logic signed [sampleWidth+cicOrder*$clog2(cicRate)-1:0] integ1;
    logic signed [sampleWidth+cicOrder*$clog2(cicRate)-1:0] integ2;
    logic signed [sampleWidth+cicOrder*$clog2(cicRate)-1:0] integ1Next;
    logic signed [sampleWidth+cicOrder*$clog2(cicRate)-1:0] integ2Next;
    logic signed [sampleWidth+cicOrder*$clog2(cicRate)-1:0] comb1Dly;
    logic signed [sampleWidth+cicOrder*$clog2(cicRate)-1:0] comb2Dly;
    logic signed [sampleWidth+cicOrder*$clog2(cicRate)-1:0] comb1;
    logic signed [sampleWidth+cicOrder*$clog2(cicRate)-1:0] comb2;
    logic signed [sampleWidth+cicOrder*$clog2(cicRate)-1:0] combScaled;
    logic [$clog2(cicRate)-1:0] count;
    logic lastInput;

    assign lastInput = sampleValid && (count == ($clog2(cicRate))'(cicRate - 1));

    always_comb begin
        integ1Next = integ1 + sampleIn;    // integrators include the current input
        integ2Next = integ2 + integ1Next;
        comb1 = integ2Next - comb1Dly;
        comb2 = comb1 - comb2Dly;
        combScaled = comb2 >>> cicShift;    // back to unity DC gain
    end

    always_ff @(posedge clk) begin
        if (rst || bypass) begin
            integ1 <= '0;
            integ2 <= '0;
            comb1Dly <= '0;
            comb2Dly <= '0;
            count <= '0;
        end else if (sampleValid) begin
            integ1 <= integ1Next;
            integ2 <= integ2Next;
            count <= lastInput ? '0 : count + 1'b1;
            if (lastInput) begin
                comb1Dly <= integ2Next;
                comb2Dly <= comb1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
        end else begin
            outValid <= bypass ? sampleValid : lastInput;
        end
    end

    always_ff @(posedge clk) begin
        if (bypass) begin
            if (sampleValid) begin
                sampleOut <= sampleIn;
            end
        end else if (lastInput) begin
            sampleOut <= combScaled[sampleWidth-1:0];
        end
    end

endmodule

// ==== verilog/halfbandDecimator.sv ====
module halfbandDecimator import ddcPkg::*; (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          bypass,
    input  logic signed [sampleWidth-1:0] sampleIn,
    input  logic                          sampleValid,
    output logic signed [sampleWidth-1:0] sampleOut,
    output logic                          outValid
);

    // tap 0 is the incoming sample, taps 1 to 6 are registered
    logic signed [sampleWidth-1:0] delayLine [1:6];
    logic signed [sampleWidth+5:0] acc;
    logic signed [sampleWidth+5:0] filtered;
    logic signed [sampleWidth-1:0] filteredSat;
    logic [$clog2(hbRate)-1:0] count;
    logic lastInput;

    assign lastInput = sampleValid && (count == ($clog2(hbRate))'(hbRate - 1));

    always_comb begin
        acc = 9 * delayLine[2] + 16 * delayLine[3] + 9 * delayLine[4]
            - sampleIn - delayLine[6];    // zero taps at 1 and 5 are skipped
        filtered = acc >>> 5;    // coefficients sum to 32
        if (filtered > (2**(sampleWidth-1)) - 1) begin
            filteredSat = {1'b0, {(sampleWidth-1){1'b1}}};
        end else if (filtered < -(2**(sampleWidth-1))) begin
            filteredSat = {1'b1, {(sampleWidth-1){1'b0}}};
        end else begin
            filteredSat = filtered[sampleWidth-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst || bypass) begin
            for (int k = 1; k <= 6; k++) begin
                delayLine[k] <= '0;
            end
            count <= '0;
        end else if (sampleValid) begin
            delayLine[1] <= sampleIn;
            for (int k = 2; k <= 6; k++) begin
                delayLine[k] <= delayLine[k-1];
            end
            count <= lastInput ? '0 : count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
        end else begin
            outValid <= bypass ? sampleValid : lastInput;
        end
    end

    always_ff @(posedge clk) begin
        if (bypass) begin
            if (sampleValid) begin
                sampleOut <= sampleIn;
            end
        end else if (lastInput) begin
            sampleOut <= filteredSat;
        end
    end

endmodule

// ==== verilog/ddcTop.sv ====
module ddcTop import ddcPkg::*; (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [regAddrWidth-1:0]       addr,
    input  logic [31:0]                   dataIn,
    input  logic [3:0]                    byteEn,
    input  logic                          cs,
    input  logic                          wr,
    output logic [31:0]                   dataOut,
    input  logic signed [sampleWidth-1:0] sampleIn,
    input  logic                          sampleValid,
    output logic signed [sampleWidth-1:0] iOut,
    output logic signed [sampleWidth-1:0] qOut,
    output logic                          outValid
);

    logic [phaseWidth-1:0] centerFreq;
    logic bypassCic;
    logic bypassHb;
    logic swapIq;
    logic signed [loWidth-1:0] loCos;
    logic signed [loWidth-1:0] loSin;
    logic signed [sampleWidth-1:0] iMix;
    logic signed [sampleWidth-1:0] qMix;
    logic mixValid;
    logic signed [sampleWidth-1:0] iCic;
    logic signed [sampleWidth-1:0] qCic;
    logic cicValid;

    ddcRegs i_regs (.clk, .rst, .addr, .dataIn, .byteEn, .cs, .wr, .dataOut,
        .centerFreq, .bypassCic, .bypassHb, .swapIq);

    ddcNco i_nco (.clk, .rst, .sampleValid, .centerFreq, .loCos, .loSin);

    ddcMixer i_mixer (.clk, .rst, .sampleIn, .sampleValid, .loCos, .loSin, .swapIq,
        .iMix, .qMix, .mixValid);

    cicDecimator i_cicI (.clk, .rst, .bypass(bypassCic), .sampleIn(iMix),
        .sampleValid(mixValid), .sampleOut(iCic), .outValid(cicValid));

    // the Q strobe matches the I strobe
    cicDecimator i_cicQ (.clk, .rst, .bypass(bypassCic), .sampleIn(qMix),
        .sampleValid(mixValid), .sampleOut(qCic), .outValid());

    halfbandDecimator i_hbI (.clk, .rst, .bypass(bypassHb), .sampleIn(iCic),
        .sampleValid(cicValid), .sampleOut(iOut), .outValid(outValid));

    halfbandDecimator i_hbQ (.clk, .rst, .bypass(bypassHb), .sampleIn(qCic),
        .sampleValid(cicValid), .sampleOut(qOut), .outValid());

endmodule

// ==== verification/ddcTb.sv ====
module ddcTb import ddcPkg::*; ();

    localparam int maxTests = 16;
    localparam int drainCycles = 20;
    localparam int marginCycles = 1000;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic [regAddrWidth-1:0] addr = '0;
    logic [31:0] dataIn = '0;
    logic [3:0] byteEn = '0;
    logic cs = 1'b0;
    logic wr = 1'b0;
    logic [31:0] dataOut;
    logic signed [sampleWidth-1:0] sampleIn = '0;
    logic sampleValid = 1'b0;
    logic signed [sampleWidth-1:0] iOut;
    logic signed [sampleWidth-1:0] qOut;
    logic outValid;

    int cycle = 0;
    int errors = 0;
    int checks = 0;
    int numTests = 0;
    int totalSamples = 0;
    bit tableReady = 1'b0;
    logic [31:0] rngState = 32'd12794;
    int inCycles [$];
    int outCycles [$];
    int outI [$];
    int outQ [$];

    // stimulus table with one row per test
    logic [31:0] tFreq [maxTests];
    logic [2:0] tCtrl [maxTests];
    int tSample [maxTests];
    int tNumIn [maxTests];
    int tExpCount [maxTests];
    int tCheckFrom [maxTests];    // index of the first compared output or -1 for count only
    bit tRandom [maxTests];
    int tExpI [maxTests][4];    // expected values repeat with the quarter-rate period
    int tExpQ [maxTests][4];

    ddcTop i_dut (.clk, .rst, .addr, .dataIn, .byteEn, .cs, .wr, .dataOut,
        .sampleIn, .sampleValid, .iOut, .qOut, .outValid);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (!rst && sampleValid) begin
            inCycles.push_back(cycle);
        end
        if (!rst && outValid) begin
            outI.push_back(iOut);
            outQ.push_back(qOut);
            outCycles.push_back(cycle);
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // scales the product with the oscillator down by 15 bits and saturates it
    function automatic int mixScale(input int x, input int lo);
        longint p;
        p = (longint'(x) * longint'(lo)) >>> 15;
        if (p > 32767) begin
            p = 32767;
        end else if (p < -32768) begin
            p = -32768;
        end
        return int'(p);
    endfunction

    function automatic int loCosAt(input bit quarter, input int p);
        if (!quarter) begin
            return 32767;
        end
        case (p)
            0: return 32767;
            2: return -32767;
            default: return 0;
        endcase
    endfunction

    function automatic int loSinAt(input bit quarter, input int p);
        if (!quarter) begin
            return 0;
        end
        case (p)
            1: return 32767;
            3: return -32767;
            default: return 0;
        endcase
    endfunction

    function automatic logic [2:0] ctrlBits(input bit cicOff, input bit hbOff, input bit swap);
        logic [2:0] c;
        c = '0;
        c[bypassCicBit] = cicOff;
        c[bypassHbBit] = hbOff;
        c[swapIqBit] = swap;
        return c;
    endfunction

    function automatic void addTest(input bit quarter, input logic [2:0] ctrl, input int x,
        input int n, input int expCount, input int checkFrom, input bit isRandom);
        int iv;
        int qv;
        tFreq[numTests] = quarter ? 32'h4000_0000 : 32'h0;    // a quarter turn per sample
        tCtrl[numTests] = ctrl;
        tSample[numTests] = x;
        tNumIn[numTests] = n;
        tExpCount[numTests] = expCount;
        tCheckFrom[numTests] = checkFrom;
        tRandom[numTests] = isRandom;
        for (int p = 0; p < 4; p++) begin
            iv = mixScale(x, loCosAt(quarter, p));
            qv = mixScale(x, -loSinAt(quarter, p));
            tExpI[numTests][p] = ctrl[swapIqBit] ? qv : iv;
            tExpQ[numTests][p] = ctrl[swapIqBit] ? iv : qv;
        end
        totalSamples += n;
        numTests++;
    endfunction

    // quarter-rate rows use multiples of four samples so the phase returns to zero
    function automatic void loadTable();
        addTest(1'b0, ctrlBits(1, 1, 0), 1000, 8, 8, 0, 1'b0);
        addTest(1'b0, ctrlBits(1, 1, 0), -12345, 8, 8, 0, 1'b0);
        addTest(1'b1, ctrlBits(1, 1, 0), 20000, 8, 8, 0, 1'b0);
        addTest(1'b0, ctrlBits(1, 1, 1), 1000, 8, 8, 0, 1'b0);
        addTest(1'b1, ctrlBits(1, 1, 1), 20000, 8, 8, 0, 1'b0);
        addTest(1'b0, ctrlBits(1, 1, 0), 0, 64, 64, -1, 1'b1);
        addTest(1'b0, ctrlBits(0, 1, 0), 0, 64, 64 / cicRate, -1, 1'b1);
        addTest(1'b0, ctrlBits(1, 0, 0), 0, 64, 64 / hbRate, -1, 1'b1);
        addTest(1'b0, ctrlBits(0, 0, 0), 0, 64, 64 / (cicRate * hbRate), -1, 1'b1);
        addTest(1'b0, ctrlBits(0, 0, 0), 1000, 64, 64 / (cicRate * hbRate), 4, 1'b0);
        addTest(1'b0, ctrlBits(0, 0, 0), -7000, 64, 64 / (cicRate * hbRate), 4, 1'b0);
    endfunction

    task automatic hostWrite(input logic [regAddrWidth-1:0] a, input logic [31:0] d,
        input logic [3:0] be);
        @(posedge clk);
        addr <= a;
        dataIn <= d;
        byteEn <= be;
        cs <= 1'b1;
        wr <= 1'b1;
        @(posedge clk);
        cs <= 1'b0;
        wr <= 1'b0;
    endtask

    task automatic readCheck(input logic [regAddrWidth-1:0] a, input bit sel,
        input logic [31:0] expected);
        @(posedge clk);
        addr <= a;
        cs <= sel;
        wr <= 1'b0;
        @(posedge clk);
        checks++;
        if (dataOut !== expected) begin
            errors++;
            $display("Error at %0t: read of %h with cs %b gave %h, expected %h",
                $time, a, sel, dataOut, expected);
        end
        cs <= 1'b0;
    endtask

    task automatic registerTest();
        hostWrite(ddcCenterFreqAddr, 32'h1122_3344, 4'hF);
        readCheck(ddcCenterFreqAddr, 1'b1, 32'h1122_3344);
        hostWrite(ddcCenterFreqAddr, 32'hAABB_CCDD, 4'b0101);
        readCheck(ddcCenterFreqAddr, 1'b1, 32'h11BB_33DD);    // lanes 1 and 3 keep their bytes
        hostWrite(ddcControlAddr, 32'hFFFF_FF05, 4'b0001);
        readCheck(ddcControlAddr, 1'b1, 32'h0000_0005);    // only the flags read back
        hostWrite(ddcControlAddr, 32'h0000_0002, 4'b1110);    // lane 0 off leaves the flags alone
        readCheck(ddcControlAddr, 1'b1, 32'h0000_0005);
        readCheck(12'h008, 1'b1, 32'h0);
        readCheck(ddcCenterFreqAddr, 1'b0, 32'h0);
    endtask

    task automatic runTest(input int t);
        int waited;
        bit bothBypassed;
        hostWrite(ddcControlAddr, 32'(ctrlBits(1, 1, 0)), 4'h1);    // clears the filter state
        hostWrite(ddcCenterFreqAddr, tFreq[t], 4'hF);
        hostWrite(ddcControlAddr, 32'(tCtrl[t]), 4'h1);
        bothBypassed = tCtrl[t][bypassCicBit] && tCtrl[t][bypassHbBit];
        outI.delete();
        outQ.delete();
        outCycles.delete();
        inCycles.delete();
        for (int n = 0; n < tNumIn[t]; n++) begin
            @(posedge clk);
            if (tRandom[t]) begin
                rngState = xorshift(rngState);
                sampleIn <= rngState[sampleWidth-1:0];
            end else begin
                sampleIn <= sampleWidth'(tSample[t]);
            end
            sampleValid <= 1'b1;
        end
        @(posedge clk);
        sampleValid <= 1'b0;
        waited = 0;
        while (outI.size() < tExpCount[t] && waited < tNumIn[t] * 4 + drainCycles) begin
            @(posedge clk);
            waited++;
        end
        repeat (drainCycles) @(posedge clk);    // catches any surplus outputs
        checks++;
        if (outI.size() != tExpCount[t]) begin
            errors++;
            $display("Test %0d produced %0d outputs but %0d were expected",
                t, outI.size(), tExpCount[t]);
        end
        for (int k = 0; k < outI.size() && k < tExpCount[t]; k++) begin
            if (tCheckFrom[t] >= 0 && k >= tCheckFrom[t]) begin
                checks++;
                if (outI[k] != tExpI[t][k % 4] || outQ[k] != tExpQ[t][k % 4]) begin
                    errors++;
                    $display("Error at %0t: test %0d output %0d is (%0d, %0d), expected (%0d, %0d)",
                        $time, t, k, outI[k], outQ[k], tExpI[t][k % 4], tExpQ[t][k % 4]);
                end
            end
            if (bothBypassed && k < inCycles.size()) begin
                checks++;
                if (outCycles[k] - inCycles[k] != 3) begin
                    errors++;
                    $display("Test %0d output %0d arrived %0d cycles after its input, not 3",
                        t, k, outCycles[k] - inCycles[k]);
                end
            end
        end
    endtask

    initial begin
        wait (tableReady);
        repeat (totalSamples * 4 + marginCycles) @(posedge clk);
        $display("Watchdog expired before all tests finished, %0d errors so far", errors);
        $display("Test failures found");
        $finish;
    end

    initial begin
        loadTable();
        tableReady = 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        registerTest();
        for (int t = 0; t < numTests; t++) begin
            runTest(t);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== ddc.f ====
verilog/ddcPkg.sv
verilog/ddcRegs.sv
verilog/ddcNco.sv
verilog/ddcMixer.sv
verilog/cicDecimator.sv
verilog/halfbandDecimator.sv
verilog/ddcTop.sv
verification/ddcTb.sv

// ==== Bender.yml ====
package:
  name: ddc

sources:
  - verilog/ddcPkg.sv
  - verilog/ddcRegs.sv
  - verilog/ddcNco.sv
  - verilog/ddcMixer.sv
  - verilog/cicDecimator.sv
  - verilog/halfbandDecimator.sv
  - verilog/ddcTop.sv
  - target: test
    files:
      - verification/ddcTb.sv
